// File: Makefile
# Verilator build and run of the ALU testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_alu_top
FILELIST  := verilog.f
OBJ_DIR   := obj_dir

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only when the pass line appears in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// File: alu_adder_compare.sv
// ----------------------------------------
// Shared adder and comparison unit
// Add/subtract with carry-in, less-than for
// SLT and branches, branch resolution
// ----------------------------------------

module alu_adder_compare (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  alu_op_pkg::alu_op_e op_i,
    input  alu_cfg_pkg::xlen_t  operand_a_i,
    input  alu_cfg_pkg::xlen_t  operand_b_i,
    output alu_cfg_pkg::xlen_t  adder_result_o,
    output alu_cfg_pkg::xlen_t  operand_b_eff_o,
    output logic                less_o,
    output logic                branch_res_o
);
    import alu_cfg_pkg::*;
    import alu_op_pkg::*;

    logic negate_b;
    logic signed_cmp;
    logic adder_zero;

    // Operand B is inverted for subtraction and the N logic variants
    always_comb begin
        unique case (op_i)
            SUB, EQ, NE, ANDN, ORN, XNOR: negate_b = 1'b1;
            default:                      negate_b = 1'b0;
        endcase
    end

    assign operand_b_eff_o = negate_b ? ~operand_b_i : operand_b_i;

    // Two's complement via carry-in
    assign adder_result_o = operand_a_i + operand_b_eff_o + {{(XLEN-1){1'b0}}, negate_b};
    assign adder_zero     = ~|adder_result_o;

    // ----------------------------------------
    // Less-than, one extra bit picks the sign
    // ----------------------------------------
    assign signed_cmp = (op_i == SLTS) || (op_i == LTS) || (op_i == GES);

    assign less_o = $signed({signed_cmp & operand_a_i[XLEN-1], operand_a_i}) <
                    $signed({signed_cmp & operand_b_i[XLEN-1], operand_b_i});

    always_comb begin
        case (op_i)
            EQ:       branch_res_o = adder_zero;
            NE:       branch_res_o = ~adder_zero;
            LTS, LTU: branch_res_o = less_o;
            GES, GEU: branch_res_o = ~less_o;
            default:  branch_res_o = 1'b1;
        endcase
    end

    // Non-branch operations never report a failed comparison
    a_branch_idle : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(op_i inside {EQ, NE, LTS, LTU, GES, GEU}) |-> branch_res_o
    );

endmodule

// File: alu_cfg_pkg.sv
// ----------------------------------------
// ALU datapath configuration
// Word width, shift amount width and the
// geometry of the polar lanes
// ----------------------------------------

package alu_cfg_pkg;

    // Data word
    localparam int XLEN = 32;
    typedef logic [XLEN-1:0] xlen_t;

    // Shift amount bits taken from operand B
    localparam int SHAMT_W = $clog2(XLEN);

    // Polar lanes, one per byte of the word
    localparam int LANE_W = 8;
    localparam int LANES = XLEN / LANE_W;
    typedef logic signed [LANE_W-1:0] lane_t;

    // Symmetric clamp for the polar add and subtract
    localparam int SAT_MAX = (2 ** (LANE_W - 1)) - 1;

endpackage

// File: alu_op_pkg.sv
// ----------------------------------------
// ALU operation codes
// Numeric order is fixed, the trace vectors
// use the raw codes
// ----------------------------------------

package alu_op_pkg;

    typedef enum logic [4:0] {
        // Adder and logic
        ADD       = 5'd0,
        SUB       = 5'd1,
        XORL      = 5'd2,
        ORL       = 5'd3,
        ANDL      = 5'd4,
        XNOR      = 5'd5,
        ORN       = 5'd6,
        ANDN      = 5'd7,
        // Shifts and set-less-than
        SLL       = 5'd8,
        SRL       = 5'd9,
        SRA       = 5'd10,
        SLTS      = 5'd11,
        SLTU      = 5'd12,
        // Branch comparisons
        EQ        = 5'd13,
        NE        = 5'd14,
        LTS       = 5'd15,
        LTU       = 5'd16,
        GES       = 5'd17,
        GEU       = 5'd18,
        // Polar decoding, per 8-bit lane
        PL_F      = 5'd19,
        PL_G      = 5'd20,
        PL_R      = 5'd21,
        PL_DECODE = 5'd22
    } alu_op_e;

endpackage

// File: alu_result_mux.sv
// ----------------------------------------
// ALU result multiplexer
// Logic operations and the choice of the
// producer word per operation
// ----------------------------------------

module alu_result_mux (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  alu_op_pkg::alu_op_e op_i,
    input  alu_cfg_pkg::xlen_t  operand_a_i,
    input  alu_cfg_pkg::xlen_t  operand_b_eff_i,
    input  alu_cfg_pkg::xlen_t  adder_result_i,
    input  alu_cfg_pkg::xlen_t  shift_result_i,
    input  alu_cfg_pkg::xlen_t  polar_result_i,
    input  logic                less_i,
    output alu_cfg_pkg::xlen_t  result_o
);
    import alu_cfg_pkg::*;
    import alu_op_pkg::*;

    xlen_t and_result;
    xlen_t or_result;
    xlen_t xor_result;

    // B is already inverted for the N variants
    assign and_result = operand_a_i & operand_b_eff_i;
    assign or_result  = operand_a_i | operand_b_eff_i;
    assign xor_result = operand_a_i ^ operand_b_eff_i;

    always_comb begin
        unique case (op_i)
            ADD, SUB:                      result_o = adder_result_i;
            ANDL, ANDN:                    result_o = and_result;
            ORL, ORN:                      result_o = or_result;
            XORL, XNOR:                    result_o = xor_result;
            SLL, SRL, SRA:                 result_o = shift_result_i;
            SLTS, SLTU:                    result_o = {{(XLEN-1){1'b0}}, less_i};
            PL_F, PL_G, PL_R, PL_DECODE:   result_o = polar_result_i;
            // Branches only report through the branch flag
            EQ, NE, LTS, LTU, GES, GEU:    result_o = '0;
            default:                       result_o = '0;
        endcase
    end

    // All producers must settle to known values
    a_result_known : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(result_o)
    );

endmodule

// File: alu_shifter.sv
// ----------------------------------------
// Barrel shifter
// One arithmetic right shifter, left shifts
// go through bit reversal on both sides
// ----------------------------------------

module alu_shifter (
    input  alu_op_pkg::alu_op_e op_i,
    input  alu_cfg_pkg::xlen_t  operand_a_i,
    input  alu_cfg_pkg::xlen_t  operand_b_i,
    output alu_cfg_pkg::xlen_t  shift_result_o
);
    import alu_cfg_pkg::*;
    import alu_op_pkg::*;

    logic               shift_left;
    logic               shift_arith;
    logic [SHAMT_W-1:0] shamt;
    xlen_t              operand_a_rev;
    xlen_t              shift_in;
    logic [XLEN:0]      shift_ext;
    xlen_t              right_result;
    xlen_t              left_result;

    assign shift_left  = (op_i == SLL);
    assign shift_arith = (op_i == SRA);

    // Upper bits of operand B are ignored
    assign shamt = operand_b_i[SHAMT_W-1:0];

    for (genvar k = 0; k < XLEN; k++) begin : gen_rev
        assign operand_a_rev[k] = operand_a_i[XLEN-1-k];
        assign left_result[k]   = right_result[XLEN-1-k];
    end

    assign shift_in = shift_left ? operand_a_rev : operand_a_i;

    // Sign fill only for SRA, zero otherwise
    assign shift_ext    = {shift_arith & shift_in[XLEN-1], shift_in};
    assign right_result = XLEN'($signed(shift_ext) >>> shamt);

    assign shift_result_o = shift_left ? left_result : right_result;

endmodule

// File: alu_top.sv
// ----------------------------------------
// ALU top level
// Adder, shifter and polar unit in parallel
// feeding the result multiplexer
// ----------------------------------------

module alu_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  alu_op_pkg::alu_op_e op_i,
    input  alu_cfg_pkg::xlen_t  operand_a_i,
    input  alu_cfg_pkg::xlen_t  operand_b_i,
    input  alu_cfg_pkg::xlen_t  imm_i,
    output alu_cfg_pkg::xlen_t  result_o,
    output logic                branch_res_o
);
    import alu_cfg_pkg::*;

    xlen_t adder_result;
    xlen_t operand_b_eff;
    xlen_t shift_result;
    xlen_t polar_result;
    logic  less;

    alu_adder_compare i_adder_compare (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .op_i            (op_i),
        .operand_a_i     (operand_a_i),
        .operand_b_i     (operand_b_i),
        .adder_result_o  (adder_result),
        .operand_b_eff_o (operand_b_eff),
        .less_o          (less),
        .branch_res_o    (branch_res_o)
    );

    alu_shifter i_shifter (
        .op_i           (op_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .shift_result_o (shift_result)
    );

    polar_lane_unit i_polar (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .op_i           (op_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .imm_i          (imm_i),
        .polar_result_o (polar_result)
    );

    alu_result_mux i_result_mux (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .op_i            (op_i),
        .operand_a_i     (operand_a_i),
        .operand_b_eff_i (operand_b_eff),
        .adder_result_i  (adder_result),
        .shift_result_i  (shift_result),
        .polar_result_i  (polar_result),
        .less_i          (less),
        .result_o        (result_o)
    );

endmodule

// File: alu_trace.txt
// ALU test vectors, one per line, all fields in hex
// op  operand_a  operand_b  imm  expected_result  expected_branch
// Adder and logic
00 00000005 00000007 00000000 0000000c 1
00 ffffffff 00000002 00000000 00000001 1
01 00000003 00000005 00000000 fffffffe 1
01 80000000 00000001 00000000 7fffffff 1
02 f0f0a5a5 ff00ff00 00000000 0ff05aa5 1
03 12340000 0000abcd 00000000 1234abcd 1
04 f0f0a5a5 ff00ff00 00000000 f000a500 1
05 f0f0a5a5 ff00ff00 00000000 f00fa55a 1
06 00000000 ffff0000 00000000 0000ffff 1
07 f0f0a5a5 ff00ff00 00000000 00f000a5 1
// Shifts, amount from b[4:0]
08 00000001 00000000 00000000 00000001 1
08 80000001 00000001 00000000 00000002 1
08 00000001 0000003f 00000000 80000000 1
09 80000000 00000001 00000000 40000000 1
09 80000000 ffffffff 00000000 00000001 1
0a 80000000 00000001 00000000 c0000000 1
0a 80000000 0000001f 00000000 ffffffff 1
0a f0000000 00000000 00000000 f0000000 1
0a 7fffffff 00000021 00000000 3fffffff 1
// Set-less-than, signed and unsigned order differ
0b ffffffff 00000001 00000000 00000001 1
0c ffffffff 00000001 00000000 00000000 1
0b 00000001 ffffffff 00000000 00000000 1
0c 00000001 ffffffff 00000000 00000001 1
// Branch comparisons
0d 12345678 12345678 00000000 00000000 1
0d 12345678 12345679 00000000 00000000 0
0e 12345678 12345679 00000000 00000000 1
0e 00000000 00000000 00000000 00000000 0
0f ffffffff 00000001 00000000 00000000 1
10 ffffffff 00000001 00000000 00000000 0
11 ffffffff 00000001 00000000 00000000 0
12 ffffffff 00000001 00000000 00000000 1
11 00000005 00000005 00000000 00000000 1
12 00000004 00000005 00000000 00000000 0
// Polar F, mixed signs and equal magnitudes
13 05fb10f0 0307f010 00000000 03fbf0f0 1
13 817f00c0 028105c0 00000000 fe810040 1
// Polar G, each lane clamps on its own
14 649c10f0 649c2005 00000000 7f8130f5 1
14 9c641005 649c20f0 01010101 7f8110eb 1
14 7f7f8101 0181817f 00ff0080 7f81817e 1
// Polar R and DECODE, control from b[7:0]
15 80ff017f 00000001 00000000 00000000 1
15 80ff017f 00000000 00000000 01010000 1
15 80ff017f 12345605 00000000 01010000 1
16 80ff017f ffffff00 00000000 80ff017f 1
16 80ff017f 00000001 00000000 00000000 1
16 80ff017f 00000042 00000000 00000000 1

// File: polar_lane_unit.sv
// ----------------------------------------
// Polar decoding unit
// F, G, R and DECODE on each 8-bit lane,
// G clamps to +/-127
// ----------------------------------------

module polar_lane_unit (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  alu_op_pkg::alu_op_e op_i,
    input  alu_cfg_pkg::xlen_t  operand_a_i,
    input  alu_cfg_pkg::xlen_t  operand_b_i,
    input  alu_cfg_pkg::xlen_t  imm_i,
    output alu_cfg_pkg::xlen_t  polar_result_o
);
    import alu_cfg_pkg::*;
    import alu_op_pkg::*;

    lane_t [LANES-1:0] lane_res;

    // Clamp a 9-bit sum into the lane range
    function automatic lane_t sat_lane(input logic signed [LANE_W:0] value);
        if (value > SAT_MAX) begin
            return lane_t'(SAT_MAX);
        end else if (value < -SAT_MAX) begin
            return lane_t'(-SAT_MAX);
        end
        return value[LANE_W-1:0];
    endfunction

    for (genvar i = 0; i < LANES; i++) begin : gen_lane
        lane_t                   a_l;
        lane_t                   b_l;
        lane_t                   imm_l;
        logic [LANE_W-1:0]       abs_a;
        logic [LANE_W-1:0]       abs_b;
        logic [LANE_W-1:0]       mag;
        logic                    sign_diff;
        logic signed [LANE_W:0]  sum;
        logic signed [LANE_W:0]  diff;
        lane_t                   f_res;
        lane_t                   g_res;
        lane_t                   r_res;
        lane_t                   dec_res;
        lane_t                   sel;

        assign a_l   = operand_a_i[i*LANE_W +: LANE_W];
        assign b_l   = operand_b_i[i*LANE_W +: LANE_W];
        assign imm_l = imm_i[i*LANE_W +: LANE_W];

        // F: smaller magnitude, sign from the product of signs
        assign abs_a     = a_l[LANE_W-1] ? -a_l : a_l;
        assign abs_b     = b_l[LANE_W-1] ? -b_l : b_l;
        assign sign_diff = a_l[LANE_W-1] ^ b_l[LANE_W-1];
        assign mag       = (abs_a > abs_b) ? abs_b : abs_a;
        assign f_res     = sign_diff ? -mag : mag;

        // G: one extra bit keeps the overflow visible
        assign sum   = (LANE_W+1)'(a_l) + (LANE_W+1)'(b_l);
        assign diff  = (LANE_W+1)'(b_l) - (LANE_W+1)'(a_l);
        assign g_res = (imm_l == '0) ? sat_lane(sum) : sat_lane(diff);

        // Frozen-bit control comes from the low byte of B
        assign r_res   = (operand_b_i[LANE_W-1:0] == LANE_W'(1)) ? '0 :
                         (a_l[LANE_W-1] ? lane_t'(1) : '0);
        assign dec_res = (operand_b_i[LANE_W-1:0] == '0) ? a_l : '0;

        always_comb begin
            unique case (op_i)
                PL_F:      sel = f_res;
                PL_G:      sel = g_res;
                PL_R:      sel = r_res;
                PL_DECODE: sel = dec_res;
                default:   sel = '0;
            endcase
        end

        assign lane_res[i] = sel;

        // Saturation is symmetric, -128 must never appear
        a_g_no_min : assert property (
            @(posedge clk_i) disable iff (!rst_n_i)
            (op_i == PL_G) |-> (lane_res[i] != lane_t'(-SAT_MAX - 1))
        );
    end

    assign polar_result_o = lane_res;

endmodule

// File: tb_alu_top.sv
// ----------------------------------------
// Testbench for the ALU top level
// Replays the vector trace and checks the
// result word and the branch flag
// ----------------------------------------

module tb_alu_top;
    timeunit 1ns;
    timeprecision 100ps;

    import alu_cfg_pkg::*;
    import alu_op_pkg::*;

    localparam int    CLK_PERIOD   = 4;
    localparam int    RESET_CYCLES = 8;
    localparam int    SLACK_CYCLES = 20;
    localparam int    MAX_VECTORS  = 64;
    localparam int    FIELDS       = 6;
    localparam string TRACE_FILE   = "alu_trace.txt";

    logic    clk_i;
    logic    rst_n_i;
    alu_op_e op_i;
    xlen_t   operand_a_i;
    xlen_t   operand_b_i;
    xlen_t   imm_i;
    xlen_t   result_o;
    logic    branch_res_o;

    // Six words per vector: op, a, b, imm, result, branch
    logic [31:0] trace_mem [MAX_VECTORS*FIELDS];
    int          num_vectors;
    bit          trace_loaded;

    alu_top alu_top_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .op_i         (op_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .imm_i        (imm_i),
        .result_o     (result_o),
        .branch_res_o (branch_res_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_result(input string test_name, input xlen_t expected,
                                input xlen_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("error %s result expected %08h actual %08h",
                                test_name, expected, actual));
        end
    endtask

    task automatic check_branch(input string test_name, input logic expected,
                                input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("error %s branch expected %0b actual %0b",
                                test_name, expected, actual));
        end
    endtask

    task automatic load_trace();
        int fd;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            abort_run({"Trace file ", TRACE_FILE, " could not be opened"});
        end else begin
            $fclose(fd);
            // Unwritten words carry a tag that no opcode can match
            for (int k = 0; k < MAX_VECTORS * FIELDS; k++) begin
                trace_mem[k] = {16'hbad0, 16'(k)};
            end
            $readmemh(TRACE_FILE, trace_mem);
            num_vectors = 0;
            while (num_vectors < MAX_VECTORS &&
                   trace_mem[num_vectors * FIELDS][31:5] == '0) begin
                num_vectors++;
            end
        end
    endtask

    task automatic run_vector(input int idx);
        int    base;
        string test_name;
        base = idx * FIELDS;
        @(posedge clk_i);
        #1;
        op_i        = alu_op_e'(trace_mem[base][4:0]);
        operand_a_i = trace_mem[base + 1];
        operand_b_i = trace_mem[base + 2];
        imm_i       = trace_mem[base + 3];
        test_name   = $sformatf("vector %0d %s", idx, op_i.name());
        // Outputs are combinational, sample mid-cycle
        #2;
        check_result(test_name, trace_mem[base + 4], result_o);
        check_branch(test_name, trace_mem[base + 5][0], branch_res_o);
    endtask

    initial begin : main
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        op_i        = ADD;
        operand_a_i = '0;
        operand_b_i = '0;
        imm_i       = '0;
        load_trace();
        trace_loaded = 1'b1;
        if (num_vectors == 0) begin
            abort_run("Trace file holds no test vectors");
        end else begin
            repeat (RESET_CYCLES) @(posedge clk_i);
            #1;
            rst_n_i = 1'b1;
            for (int idx = 0; idx < num_vectors; idx++) begin
                run_vector(idx);
            end
            @(posedge clk_i);
            $display("NO ERRORS");
            $finish;
        end
    end

    // Budget of one cycle per vector plus reset and slack
    initial begin : watchdog
        wait (trace_loaded);
        #((num_vectors + RESET_CYCLES + SLACK_CYCLES) * CLK_PERIOD);
        abort_run("Timeout, the trace did not finish in the expected time");
    end

endmodule

// File: verilog.f
alu_cfg_pkg.sv
alu_op_pkg.sv
alu_adder_compare.sv
alu_shifter.sv
polar_lane_unit.sv
alu_result_mux.sv
alu_top.sv
tb_alu_top.sv
